// File: include/intc_settings.svh
`ifndef INTC_SETTINGS_SVH
`define INTC_SETTINGS_SVH

// AXI4-Lite slave port
`define INTC_AXI_ADDR_W 6
`define INTC_AXI_DATA_W 32

// Input sample clock, one tick per 12 cycles
`define INTC_SAMPLE_DIV 12

// Timer counter and its prescaler
`define INTC_TIMER_W 12
`define INTC_PRESCALE_W 3

// Edge-triggered interrupt lines
`define INTC_SAMPLE_DEPTH 4
`define INTC_N_EDGE_INT 2

`endif

// File: hdl/intc_reg_pkg.sv
package intc_reg_pkg;

  typedef logic [7:0] t_byte;

  // Word index, taken from address bits 5:2
  typedef enum logic [3:0] {
    REG_PA   = 4'd0,
    REG_PB   = 4'd1,
    REG_PC   = 4'd2,
    REG_MK   = 4'd3,
    REG_MB   = 4'd4,
    REG_MC   = 4'd5,
    REG_TM0  = 4'd6,
    REG_TM1  = 4'd7,
    REG_IE   = 4'd8,
    REG_PEND = 4'd9,   // read only
    REG_STM  = 4'd10   // write only, reloads the timer
  } e_reg_addr;

  localparam int REG_IDX_LSB = 2;

  typedef logic [1:0] t_axi_resp;
  localparam t_axi_resp AXI_RESP_OKAY = 2'b00;

endpackage

// File: hdl/intc_irq_pkg.sv
package intc_irq_pkg;

  // Lower index wins
  typedef enum logic [1:0] {
    INT_IDX_INT0 = 2'd0,
    INT_IDX_INTT = 2'd1,
    INT_IDX_INT1 = 2'd2,
    INT_IDX_INT2 = 2'd3
  } e_int_idx;

  // One bit per source, indexed by e_int_idx
  typedef logic [3:0] t_int_vec;

  // Vector addresses
  localparam logic [7:0] VEC_NONE = 8'h00;
  localparam logic [7:0] VEC_INT0 = 8'h04;
  localparam logic [7:0] VEC_INTT = 8'h08;
  localparam logic [7:0] VEC_INT1 = 8'h10;
  localparam logic [7:0] VEC_INT2 = 8'h20;

endpackage

// File: hdl/cfg_if.sv
`timescale 1ns/1ps
`include "intc_settings.svh"

interface cfg_if import intc_reg_pkg::*; ();

  // Interrupt mask, bit 5 also picks the INT2 edge
  t_byte                    mk;
  // TM1:TM0 reload value
  logic [`INTC_TIMER_W-1:0] tm_reload;
  logic                     ie;
  // One cycle pulse on a write to STM
  logic                     stm_strobe;

  modport regs (
    output mk,
    output tm_reload,
    output ie,
    output stm_strobe
  );

  modport timer (input tm_reload, input stm_strobe);

  modport intc (input mk, input ie);

endinterface

// File: hdl/axil_regs.sv
`timescale 1ns/1ps
`include "intc_settings.svh"

module axil_regs import intc_reg_pkg::*; import intc_irq_pkg::*; (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic [`INTC_AXI_ADDR_W-1:0]   awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`INTC_AXI_DATA_W-1:0]   wdata,
  input  logic [`INTC_AXI_DATA_W/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output t_axi_resp                     bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [`INTC_AXI_ADDR_W-1:0]   araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`INTC_AXI_DATA_W-1:0]   rdata,
  output t_axi_resp                     rresp,
  output logic                          rvalid,
  input  logic                          rready,
  cfg_if.regs                           cfg,
  input  t_int_vec                      pending,
  output t_byte                         pa_o,
  input  t_byte                         pb_i,
  output t_byte                         pb_o,
  output t_byte                         pb_oe,
  input  t_byte                         pc_i,
  output t_byte                         pc_o,
  output t_byte                         pc_oe
);

  t_byte                    pa_q, pb_q, pc_q;
  t_byte                    mk_q, mb_q, mc_q;
  logic [`INTC_TIMER_W-1:0] tm_q;
  logic                     ie_q;
  logic                     stm_q;
  logic                     wr_fire;
  e_reg_addr                wr_idx;
  e_reg_addr                rd_idx;
  t_byte                    wr_byte;
  t_byte                    rd_byte;

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite handshakes

  // Ready pulses for one cycle, then waits for the response to drain
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~bvalid & ~awready;
      if (awready) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      arready <= arvalid & ~rvalid & ~arready;
      if (arready) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  assign wready  = awready;
  assign bresp   = AXI_RESP_OKAY;
  assign rresp   = AXI_RESP_OKAY;
  assign wr_fire = awready & awvalid & wvalid & wstrb[0];
  assign wr_idx  = e_reg_addr'(awaddr[`INTC_AXI_ADDR_W-1:REG_IDX_LSB]);
  assign rd_idx  = e_reg_addr'(araddr[`INTC_AXI_ADDR_W-1:REG_IDX_LSB]);
  assign wr_byte = wdata[7:0];

  //////////////////////////////////////////////////////////////////////
  // Register storage

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pa_q  <= '0;
      pb_q  <= '0;
      pc_q  <= '0;
      mk_q  <= 8'hff;
      mb_q  <= 8'hff;
      mc_q  <= 8'hff;
      tm_q  <= '1;
      ie_q  <= 1'b0;
      stm_q <= 1'b0;
    end else begin
      stm_q <= wr_fire & (wr_idx == REG_STM);
      if (wr_fire) begin
        case (wr_idx)
          REG_PA:  pa_q <= wr_byte;
          REG_PB:  pb_q <= wr_byte;
          REG_PC:  pc_q <= wr_byte;
          REG_MK:  mk_q <= wr_byte;
          REG_MB:  mb_q <= wr_byte;
          REG_MC:  mc_q <= wr_byte;
          REG_TM0: tm_q[7:0] <= wr_byte;
          // Only the low nibble of TM1 exists
          REG_TM1: tm_q[`INTC_TIMER_W-1:8] <= wr_byte[`INTC_TIMER_W-9:0];
          REG_IE:  ie_q <= wr_byte[0];
          default: ;
        endcase
      end
    end
  end

  // Port directions, a set mode bit means input
  assign pb_oe = ~mb_q;
  assign pc_oe = {~mc_q[7], 5'b11110, ~mc_q[1:0]};
  assign pa_o  = pa_q;
  assign pb_o  = pb_q;
  assign pc_o  = pc_q;

  assign cfg.mk         = mk_q;
  assign cfg.tm_reload  = tm_q;
  assign cfg.ie         = ie_q;
  assign cfg.stm_strobe = stm_q;

  //////////////////////////////////////////////////////////////////////
  // Readback

  // Pins for input bits, latch for output bits
  always_comb begin
    case (rd_idx)
      REG_PA:   rd_byte = pa_q;
      REG_PB:   rd_byte = (pb_i & ~pb_oe) | (pb_q & pb_oe);
      REG_PC:   rd_byte = (pc_i & ~pc_oe) | (pc_q & pc_oe);
      REG_MK:   rd_byte = mk_q;
      REG_MB:   rd_byte = mb_q;
      REG_MC:   rd_byte = mc_q;
      REG_TM0:  rd_byte = tm_q[7:0];
      REG_TM1:  rd_byte = t_byte'(tm_q[`INTC_TIMER_W-1:8]);
      REG_IE:   rd_byte = t_byte'(ie_q);
      REG_PEND: rd_byte = t_byte'(pending);
      default:  rd_byte = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (arready) rdata <= {{(`INTC_AXI_DATA_W-8){1'b0}}, rd_byte};
  end

endmodule

// File: hdl/timebase.sv
`timescale 1ns/1ps
`include "intc_settings.svh"

module timebase (
  input  logic CLK,
  input  logic rst_n,
  cfg_if.timer cfg,
  output logic sample_tick,
  output logic timer_uf
);

  localparam int DIV_W = $clog2(`INTC_SAMPLE_DIV);
  localparam int TC_W  = `INTC_TIMER_W + `INTC_PRESCALE_W;

  logic [DIV_W-1:0] div_cnt;
  // Low bits are the prescaler
  logic [TC_W-1:0]  tc;

  // Divide by 12 for the interrupt samplers
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (sample_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign sample_tick = (div_cnt == DIV_W'(`INTC_SAMPLE_DIV - 1));

  // Underflow only at zero, the STM strobe reloads silently
  assign timer_uf = (tc == '0);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tc <= '1;
    end else if (timer_uf || cfg.stm_strobe) begin
      tc <= {cfg.tm_reload, {`INTC_PRESCALE_W{1'b1}}};
    end else begin
      tc <= tc - 1'b1;
    end
  end

endmodule

// File: hdl/edge_sampler.sv
`timescale 1ns/1ps
`include "intc_settings.svh"

module edge_sampler (
  input  logic CLK,
  input  logic rst_n,
  input  logic sample_tick,
  input  logic line,
  input  logic invert,
  output logic detect
);

  localparam int DEPTH = `INTC_SAMPLE_DEPTH;
  // One deasserted sample, then the rest asserted
  localparam logic [DEPTH-1:0] MATCH = {1'b0, {(DEPTH-1){1'b1}}};

  // Oldest sample in the MSB
  logic [DEPTH-1:0] hist;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      hist <= '0;
    end else if (sample_tick) begin
      hist <= {hist[DEPTH-2:0], line ^ invert};
    end
  end

  assign detect = sample_tick & (hist == MATCH);

endmodule

// File: hdl/int_pending.sv
`timescale 1ns/1ps
`include "intc_settings.svh"

module int_pending import intc_irq_pkg::*; (
  input  logic                        CLK,
  input  logic                        rst_n,
  cfg_if.intc                         cfg,
  input  logic                        int0,
  input  logic                        timer_uf,
  input  logic [`INTC_N_EDGE_INT-1:0] edge_detect,
  input  logic                        int_ack,
  output t_int_vec                    pending,
  output logic                        irq,
  output logic [7:0]                  irq_vector
);

  localparam int N_INT = $bits(t_int_vec);

  t_int_vec pend_set;
  t_int_vec pend_clr;
  t_int_vec enable;
  t_int_vec active;
  t_int_vec first;
  // Source currently presented on irq_vector
  t_int_vec grant;

  function automatic logic [7:0] vec_addr(input t_int_vec onehot);
    logic [7:0] addr;
    addr = VEC_NONE;
    case (1'b1)
      onehot[INT_IDX_INT0]: addr = VEC_INT0;
      onehot[INT_IDX_INTT]: addr = VEC_INTT;
      onehot[INT_IDX_INT1]: addr = VEC_INT1;
      onehot[INT_IDX_INT2]: addr = VEC_INT2;
      default: ;
    endcase
    return addr;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Pending latch

  always_comb begin
    pend_set = '0;
    pend_set[INT_IDX_INT0] = int0 & ~pending[INT_IDX_INT0];
    pend_set[INT_IDX_INTT] = timer_uf;
    pend_set[INT_IDX_INT1] = edge_detect[0];
    pend_set[INT_IDX_INT2] = edge_detect[1];
  end

  // INT0 is level sensitive and also drops with its line
  always_comb begin
    pend_clr = grant & {N_INT{int_ack}};
    pend_clr[INT_IDX_INT0] = pend_clr[INT_IDX_INT0] | ~int0;
  end

  //////////////////////////////////////////////////////////////////////
  // Masking and priority

  assign enable = {N_INT{cfg.ie}} & ~cfg.mk[N_INT-1:0];
  assign active = pending & ~pend_clr & enable;
  // Isolate the lowest set bit
  assign first  = active & (~active + 1'b1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pending    <= '0;
      grant      <= '0;
      irq        <= 1'b0;
      irq_vector <= VEC_NONE;
    end else begin
      pending    <= (pending & ~pend_clr) | pend_set;
      grant      <= first;
      irq        <= |first;
      irq_vector <= vec_addr(first);
    end
  end

endmodule

// File: hdl/upd78_intc_top.sv
`timescale 1ns/1ps
`include "intc_settings.svh"

module upd78_intc_top import intc_reg_pkg::*; import intc_irq_pkg::*; (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic [`INTC_AXI_ADDR_W-1:0]   awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`INTC_AXI_DATA_W-1:0]   wdata,
  input  logic [`INTC_AXI_DATA_W/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output t_axi_resp                     bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [`INTC_AXI_ADDR_W-1:0]   araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`INTC_AXI_DATA_W-1:0]   rdata,
  output t_axi_resp                     rresp,
  output logic                          rvalid,
  input  logic                          rready,
  input  logic                          int0,
  input  logic                          int1,
  input  logic                          int2,
  input  logic                          int_ack,
  output logic                          irq,
  output t_byte                         irq_vector,
  output t_byte                         pa_o,
  input  t_byte                         pb_i,
  output t_byte                         pb_o,
  output t_byte                         pb_oe,
  input  t_byte                         pc_i,
  output t_byte                         pc_o,
  output t_byte                         pc_oe
);

  cfg_if cfg ();

  t_int_vec                    pending;
  logic                        sample_tick;
  logic                        timer_uf;
  logic [`INTC_N_EDGE_INT-1:0] edge_line;
  logic [`INTC_N_EDGE_INT-1:0] edge_inv;
  logic [`INTC_N_EDGE_INT-1:0] edge_detect;

  axil_regs u_regs (
    .CLK, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .cfg     (cfg.regs),
    .pending (pending),
    .pa_o, .pb_i, .pb_o, .pb_oe, .pc_i, .pc_o, .pc_oe
  );

  timebase u_timebase (
    .CLK, .rst_n,
    .cfg         (cfg.timer),
    .sample_tick (sample_tick),
    .timer_uf    (timer_uf)
  );

  //////////////////////////////////////////////////////////////////////
  // Edge-triggered lines

  // INT2 polarity from mk bit 5, clear selects the falling edge
  assign edge_line = {int2, int1};
  assign edge_inv  = {~cfg.mk[5], 1'b0};

  for (genvar i = 0; i < `INTC_N_EDGE_INT; i++) begin : g_edge
    edge_sampler u_sampler (
      .CLK, .rst_n,
      .sample_tick (sample_tick),
      .line        (edge_line[i]),
      .invert      (edge_inv[i]),
      .detect      (edge_detect[i])
    );
  end

  int_pending u_pending (
    .CLK, .rst_n,
    .cfg         (cfg.intc),
    .int0        (int0),
    .timer_uf    (timer_uf),
    .edge_detect (edge_detect),
    .int_ack     (int_ack),
    .pending     (pending),
    .irq         (irq),
    .irq_vector  (irq_vector)
  );

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic CLK,
  output logic rst_n
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2.0) CLK = ~CLK;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst_n <= 1'b1;
  end

endmodule

// File: testbench/upd78_intc_assert.sv
`timescale 1ns/1ps

module upd78_intc_assert import intc_reg_pkg::*; import intc_irq_pkg::*; (
  input logic  CLK,
  input logic  rst_n,
  input logic  bvalid,
  input logic  bready,
  input logic  rvalid,
  input logic  rready,
  input logic  irq,
  input t_byte irq_vector
);

  int unsigned fail_count = 0;

  // Responses hold until the master takes them
  a_bvalid_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  a_rvalid_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // An interrupt request always carries a vector
  a_irq_vector: assert property (@(posedge CLK) disable iff (!rst_n)
    irq |-> irq_vector != VEC_NONE)
    else begin
      fail_count++;
      $error("irq high with an empty vector");
    end

endmodule

bind upd78_intc_top upd78_intc_assert u_assert (
  .CLK, .rst_n, .bvalid, .bready, .rvalid, .rready, .irq, .irq_vector
);

// File: testbench/tb_top.sv
`timescale 1ns/1ps
`include "intc_settings.svh"

module tb_top import intc_reg_pkg::*; import intc_irq_pkg::*; ();

  // Longest test is the timer, at most 520 x 8 cycles, the rest stay below 3000
  localparam int WATCHDOG_CYCLES = 20000;
  localparam int HS_LIMIT        = 32;

  logic                          CLK;
  logic                          rst_n;
  logic [`INTC_AXI_ADDR_W-1:0]   awaddr, araddr;
  logic [`INTC_AXI_DATA_W-1:0]   wdata, rdata;
  logic [`INTC_AXI_DATA_W/8-1:0] wstrb;
  logic                          awvalid, awready, wvalid, wready, bvalid, bready;
  logic                          arvalid, arready, rvalid, rready;
  t_axi_resp                     bresp, rresp;
  logic                          int0, int1, int2, int_ack, irq;
  t_byte                         irq_vector, pa_o, pb_i, pb_o, pb_oe, pc_i, pc_o, pc_oe;

  logic [31:0] lfsr = 32'h2b6be23d;
  int          cycle = 0;
  int          wr_cycle;
  int          n_checks = 0;
  int          n_errors = 0;
  t_byte       model [16];
  t_byte       model_pend;

  tb_clkgen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clkgen (.CLK, .rst_n);

  upd78_intc_top u_dut (.*);

  always @(posedge CLK) cycle <= cycle + 1;

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic report_fail(input string msg);
    n_errors++;
    $display("Error: %s", msg);
  endtask

  // Output bits read back their latch, input bits the pin
  function automatic t_byte port_mix(t_byte pin, t_byte latch, t_byte oe);
    t_byte v;
    for (int i = 0; i < 8; i++) v[i] = oe[i] ? latch[i] : pin[i];
    return v;
  endfunction

  // PC7 and PC1:0 follow MC, PC6:3 always drive, PC2 is always an input
  function automatic t_byte pc_dir(t_byte mc);
    t_byte oe;
    oe    = 8'b0111_1000;
    oe[7] = !mc[7];
    oe[1] = !mc[1];
    oe[0] = !mc[0];
    return oe;
  endfunction

  function automatic t_byte expect_read(logic [3:0] idx);
    case (idx)
      REG_PB:   return port_mix(pb_i, model[REG_PB], ~model[REG_MB]);
      REG_PC:   return port_mix(pc_i, model[REG_PC], pc_dir(model[REG_MC]));
      REG_PEND: return model_pend;
      default:  return model[idx];
    endcase
  endfunction

  task automatic reg_write(input logic [3:0] idx, input t_byte data);
    int n;
    n = 0;
    awaddr  <= {idx, 2'b00};
    wdata   <= {24'h0, data};
    wstrb   <= '1;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(posedge CLK);
    while (!awready && n < HS_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    wr_cycle = cycle;
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    if (!awready) report_fail("write address and data were never accepted");
    else if (!wready) report_fail("wready was not high together with awready");
    n = 0;
    @(posedge CLK);
    if (awready || wready) report_fail("write ready stayed high for more than one cycle");
    while (!bvalid && n < HS_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    bready <= 1'b0;
    if (!bvalid) report_fail("write response never arrived");
    compare("axi bresp", AXI_RESP_OKAY, bresp);
  endtask

  task automatic reg_read(input logic [3:0] idx, output logic [31:0] data);
    int n;
    n = 0;
    araddr  <= {idx, 2'b00};
    arvalid <= 1'b1;
    @(posedge CLK);
    while (!arready && n < HS_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    arvalid <= 1'b0;
    rready  <= 1'b1;
    if (!arready) report_fail("read address was never accepted");
    n = 0;
    @(posedge CLK);
    while (!rvalid && n < HS_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    data = rdata;
    rready <= 1'b0;
    if (!rvalid) report_fail("read data never arrived");
    compare("axi rresp", AXI_RESP_OKAY, rresp);
  endtask

  // Bus write plus the matching model update
  task automatic program_reg(input logic [3:0] idx, input t_byte data);
    reg_write(idx, data);
    case (idx)
      REG_TM1: model[idx] = data & 8'h0f;
      REG_IE:  model[idx] = data & 8'h01;
      default: if (idx < REG_PEND) model[idx] = data;
    endcase
  endtask

  task automatic check_read(input string name, input logic [3:0] idx);
    logic [31:0] data;
    reg_read(idx, data);
    compare(name, {24'h0, expect_read(idx)}, data);
  endtask

  task automatic wait_pend(input string name, input int bit_idx, input int limit);
    logic [31:0] pend;
    int          start;
    pend  = '0;
    start = cycle;
    while (!pend[bit_idx] && cycle - start < limit) begin
      reg_read(REG_PEND, pend);
    end
    if (!pend[bit_idx]) report_fail({name, ": pending bit not set in time"});
  endtask

  // Waits for irq, checks the vector and acknowledges it
  task automatic ack_irq(input string name, input t_byte exp_vec);
    int n;
    n = 0;
    while (!irq && n < HS_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    if (!irq) report_fail({name, ": irq never rose"});
    compare({name, " vector"}, exp_vec, irq_vector);
    int_ack <= 1'b1;
    @(posedge CLK);
    int_ack <= 1'b0;
    @(posedge CLK);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    t_byte       data;
    logic [3:0]  idx;
    logic [11:0] tm;
    int          lat;
    int          exp_lat;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    int0    <= 1'b0;
    int1    <= 1'b0;
    int2    <= 1'b0;
    int_ack <= 1'b0;
    pb_i    <= '0;
    pc_i    <= '0;
    for (int i = 0; i < 16; i++) model[i] = 8'h00;
    model[REG_MK] = 8'hff;
    model[REG_MB] = 8'hff;
    model[REG_MC] = 8'hff;
    model_pend    = 8'h00;
    @(posedge CLK);
    while (!rst_n) @(posedge CLK);

    // Configuration readback
    for (int i = 0; i < 16; i++) begin
      idx  = REG_MK + 4'(rand_bits(3) % 6);
      data = 8'(rand_bits(8));
      // Keep INT2 rising-edge so the idle low line stays quiet
      if (idx == REG_MK) data[5] = 1'b1;
      program_reg(idx, data);
      check_read("regs readback", idx);
    end
    program_reg(REG_PEND, 8'(rand_bits(8)));
    check_read("regs pend read only", REG_PEND);
    check_read("regs stm reads zero", REG_STM);
    check_read("regs unmapped", 4'd11 + 4'(rand_bits(2)));

    // Port pins and direction
    for (int i = 0; i < 8; i++) begin
      for (int r = REG_PA; r <= REG_MC; r++) begin
        if (r != REG_MK) program_reg(4'(r), 8'(rand_bits(8)));
      end
      pb_i <= 8'(rand_bits(8));
      pc_i <= 8'(rand_bits(8));
      @(posedge CLK);
      compare("ports pa_o", model[REG_PA], pa_o);
      compare("ports pb_o", model[REG_PB], pb_o);
      compare("ports pb_oe", t_byte'(~model[REG_MB]), pb_oe);
      compare("ports pc_o", model[REG_PC], pc_o);
      compare("ports pc_oe", pc_dir(model[REG_MC]), pc_oe);
      check_read("ports pb read", REG_PB);
      check_read("ports pc read", REG_PC);
    end

    // INT0 level interrupt
    program_reg(REG_IE, 8'h01);
    program_reg(REG_MK, 8'hfe);
    int0 <= 1'b1;
    ack_irq("int0", VEC_INT0);
    compare("int0 irq after ack", 1'b0, irq);
    program_reg(REG_MK, 8'hff);
    repeat (4) @(posedge CLK);
    compare("int0 masked irq", 1'b0, irq);
    model_pend = 8'h01;
    check_read("int0 masked pend", REG_PEND);
    int0 <= 1'b0;
    repeat (4) @(posedge CLK);
    model_pend = 8'h00;
    check_read("int0 released pend", REG_PEND);

    // INT1 edge filter
    repeat (60) @(posedge CLK);
    int1 <= 1'b1;
    wait_pend("int1 edge", INT_IDX_INT1, 60);
    program_reg(REG_MK, 8'hfb);
    ack_irq("int1 edge", VEC_INT1);
    program_reg(REG_MK, 8'hff);
    int1 <= 1'b0;
    repeat (60) @(posedge CLK);
    int1 <= 1'b1;
    repeat (20) @(posedge CLK);
    int1 <= 1'b0;
    repeat (60) @(posedge CLK);
    check_read("int1 short pulse", REG_PEND);

    // INT2 rises in active-high mode, then falls with mk bit 5 clear
    int2 <= 1'b1;
    wait_pend("int2 rise", INT_IDX_INT2, 60);
    program_reg(REG_MK, 8'hd7);
    ack_irq("int2 rise", VEC_INT2);
    repeat (60) @(posedge CLK);
    int2 <= 1'b0;
    wait_pend("int2 fall", INT_IDX_INT2, 60);
    ack_irq("int2 fall", VEC_INT2);
    program_reg(REG_MK, 8'hff);

    // Timer reload and priority against INT1
    tm = 12'(rand_bits(9)) + 12'd8;
    program_reg(REG_TM0, tm[7:0]);
    program_reg(REG_TM1, {4'h0, tm[11:8]});
    program_reg(REG_MK, 8'hfd);
    int1 <= 1'b1;
    program_reg(REG_STM, 8'h00);
    exp_lat = (int'(tm) + 1) * 8;
    while (!irq && cycle - wr_cycle < exp_lat + 20) @(posedge CLK);
    // PEND sets two edges before irq is seen here
    lat = cycle - wr_cycle - 2;
    n_checks++;
    if (!irq) begin
      report_fail("timer underflow never raised irq");
    end else if (lat < exp_lat - 2 || lat > exp_lat + 2) begin
      n_errors++;
      $display("Mismatch timer latency: expected %0d, actual %0d", exp_lat, lat);
    end
    model_pend = 8'h06;
    check_read("timer pend", REG_PEND);
    program_reg(REG_MK, 8'hf9);
    ack_irq("timer prio", VEC_INTT);
    compare("timer prio next vector", VEC_INT1, irq_vector);
    program_reg(REG_MK, 8'hff);
    int1 <= 1'b0;
    repeat (4) @(posedge CLK);

    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             n_checks, n_errors, u_dut.u_assert.fail_count);
    if (n_errors == 0 && u_dut.u_assert.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
hdl/intc_reg_pkg.sv
hdl/intc_irq_pkg.sv
hdl/cfg_if.sv
hdl/axil_regs.sv
hdl/timebase.sv
hdl/edge_sampler.sv
hdl/int_pending.sv
hdl/upd78_intc_top.sv
testbench/tb_clkgen.sv
testbench/upd78_intc_assert.sv
testbench/tb_top.sv
